// ==== hdl/chip8_pkg.sv ====
//############################
// Shared types and constants for the CHIP-8 execute core
// Widths, stage and control encodings and the architectural constants
// Imported by every design module that names them
//############################
`default_nettype none

package chip8_pkg;

	// Basic data widths
	typedef logic [15:0] instr_t;
	typedef logic [11:0] addr_t;
	typedef logic [7:0]  byte_t;
	typedef logic [3:0]  reg_idx_t;

	// ALU function select
	typedef enum logic [2:0] {
		alu_nop,
		alu_add,
		alu_sub,
		alu_or,
		alu_and,
		alu_xor,
		alu_shr,
		alu_shl
	} alu_op_e;

	// Next PC source
	typedef enum logic [1:0] {
		pc_next,
		pc_skip,
		pc_jump,
		pc_stack
	} pc_src_e;

	// Return stack action
	typedef enum logic [1:0] {
		stk_hold,
		stk_push,
		stk_pop
	} stk_op_e;

	// Two stage sequence plus idle
	typedef enum logic [1:0] {
		stage_idle,
		stage_read,
		stage_exec
	} stage_e;

	// Programs start here on this machine
	localparam addr_t PC_RESET_ADDR = 12'h200;
	// Instructions are two bytes
	localparam addr_t PC_STEP = 12'd2;
	// VF holds carry, borrow and shift flags
	localparam reg_idx_t FLAG_REG = 4'hF;
	// Built-in hex font, five rows per glyph
	localparam addr_t FONT_GLYPH_BYTES = 12'd5;

endpackage

`default_nettype wire

// ==== hdl/chip8_ifs.sv ====
//############################
// Internal buses of the CHIP-8 core
// Register file, program counter and ALU traffic from the decoder
// Instanced once each in the top level
//############################
`timescale 1ns/1ps
`default_nettype none

// Register file access, two reads and two writes plus I
interface regfile_if;
	chip8_pkg::reg_idx_t rd_addr1;
	chip8_pkg::reg_idx_t rd_addr2;
	chip8_pkg::byte_t    rd_data1;
	chip8_pkg::byte_t    rd_data2;
	logic                we1;
	chip8_pkg::reg_idx_t wr_addr1;
	chip8_pkg::byte_t    wr_data1;
	// Second write port carries the flag
	logic                we2;
	chip8_pkg::reg_idx_t wr_addr2;
	chip8_pkg::byte_t    wr_data2;
	logic                i_we;
	chip8_pkg::addr_t    i_wdata;
	chip8_pkg::addr_t    i_data;

	modport exec (
		output rd_addr1, rd_addr2, we1, wr_addr1, wr_data1,
		output we2, wr_addr2, wr_data2, i_we, i_wdata,
		input  rd_data1, rd_data2, i_data
	);
	modport regfile (
		input  rd_addr1, rd_addr2, we1, wr_addr1, wr_data1,
		input  we2, wr_addr2, wr_data2, i_we, i_wdata,
		output rd_data1, rd_data2, i_data
	);
endinterface

// Next PC control and current PC
interface pc_if;
	chip8_pkg::pc_src_e pc_src;
	chip8_pkg::addr_t   jump_addr;
	chip8_pkg::stk_op_e stk_op;
	chip8_pkg::addr_t   pc_value;

	modport exec    (output pc_src, jump_addr, stk_op, input pc_value);
	modport pc_unit (input pc_src, jump_addr, stk_op, output pc_value);
endinterface

// Combinational 8-bit ALU
interface alu_if;
	chip8_pkg::alu_op_e op;
	chip8_pkg::byte_t   a;
	chip8_pkg::byte_t   b;
	chip8_pkg::byte_t   result;
	logic               flag;

	modport exec (output op, a, b, input result, flag);
	modport alu  (input op, a, b, output result, flag);
endinterface

`default_nettype wire

// ==== hdl/chip8_alu.sv ====
//############################
// 8-bit ALU of the execute stage
// Pure combinational, result and VF flag
//############################
`timescale 1ns/1ps
`default_nettype none

module chip8_alu (
	alu_if.alu alu
);
	import chip8_pkg::*;

	// Nine bit sum keeps the carry
	logic [8:0] sum;

	assign sum = {1'b0, alu.a} + {1'b0, alu.b};

	always_comb begin
		// Pass a through, flag clear
		alu.result = alu.a;
		alu.flag   = 1'b0;
		case (alu.op)
			alu_add: begin
				alu.result = sum[7:0];
				alu.flag   = sum[8];
			end
			alu_sub: begin
				alu.result = alu.a - alu.b;
				// Set when there is no borrow
				alu.flag   = (alu.a >= alu.b);
			end
			alu_or:  alu.result = alu.a | alu.b;
			alu_and: alu.result = alu.a & alu.b;
			alu_xor: alu.result = alu.a ^ alu.b;
			alu_shr: begin
				alu.result = {1'b0, alu.a[7:1]};
				// Bit shifted out
				alu.flag   = alu.a[0];
			end
			alu_shl: begin
				alu.result = {alu.a[6:0], 1'b0};
				alu.flag   = alu.a[7];
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/chip8_regfile.sv ====
//############################
// V0 to VF and the index register I
// Two async read ports, two write ports and a debug read
//############################
`timescale 1ns/1ps
`default_nettype none

module chip8_regfile (
	input  logic                cpu_clk,
	input  logic                arst_n,
	regfile_if.regfile          rf,
	input  chip8_pkg::reg_idx_t dbg_reg_addr,
	output chip8_pkg::byte_t    dbg_reg_data,
	output chip8_pkg::addr_t    index_reg
);
	import chip8_pkg::*;

	byte_t v_regs [16];
	addr_t i_reg;

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < 16; i++) begin
				v_regs[i] <= '0;
			end
			i_reg <= '0;
		end else begin
			if (rf.we1)
				v_regs[rf.wr_addr1] <= rf.wr_data1;
			// Later write wins, so VF takes the flag when x is F
			if (rf.we2)
				v_regs[rf.wr_addr2] <= rf.wr_data2;
			if (rf.i_we)
				i_reg <= rf.i_wdata;
		end
	end

	// Reads see the value before the edge
	assign rf.rd_data1   = v_regs[rf.rd_addr1];
	assign rf.rd_data2   = v_regs[rf.rd_addr2];
	assign rf.i_data     = i_reg;
	assign dbg_reg_data  = v_regs[dbg_reg_addr];
	assign index_reg     = i_reg;

	// Decoder never writes unknown addresses or data
	a_we1_known: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		rf.we1 |-> !$isunknown({rf.wr_addr1, rf.wr_data1}));
	a_we2_known: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		rf.we2 |-> !$isunknown({rf.wr_addr2, rf.wr_data2}));
	a_i_we_known: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		rf.i_we |-> !$isunknown(rf.i_wdata));

endmodule

`default_nettype wire

// ==== hdl/chip8_pc_stack.sv ====
//############################
// Program counter and return stack
// Both update on the edge that ends the execute stage
// STACK_DEPTH sets the number of nested calls
//############################
`timescale 1ns/1ps
`default_nettype none

module chip8_pc_stack #(
	parameter int unsigned STACK_DEPTH = 16
) (
	input  logic             cpu_clk,
	input  logic             arst_n,
	pc_if.pc_unit            pcs,
	input  logic             commit,
	output chip8_pkg::addr_t pc
);
	import chip8_pkg::*;

	localparam int unsigned PTR_W = $clog2(STACK_DEPTH);
	// One extra bit so a full stack is countable
	localparam int unsigned CNT_W = $clog2(STACK_DEPTH + 1);

	addr_t             pc_reg;
	addr_t             stack_mem [STACK_DEPTH];
	logic [CNT_W-1:0]  sp;
	addr_t             stack_top;
	logic              push;
	logic              pop;

	assign push      = commit && (pcs.stk_op == stk_push);
	assign pop       = commit && (pcs.stk_op == stk_pop);
	assign stack_top = stack_mem[PTR_W'(sp - 1'b1)];

	// PC and stack pointer
	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			pc_reg <= PC_RESET_ADDR;
			sp     <= '0;
		end else if (commit) begin
			case (pcs.pc_src)
				pc_next:  pc_reg <= pc_reg + PC_STEP;
				pc_skip:  pc_reg <= pc_reg + (PC_STEP << 1);
				pc_jump:  pc_reg <= pcs.jump_addr;
				pc_stack: pc_reg <= stack_top;
				default:  pc_reg <= pc_reg + PC_STEP;
			endcase
			if (push)
				sp <= sp + 1'b1;
			else if (pop)
				sp <= sp - 1'b1;
		end
	end

	// Return address is the instruction after the call
	always_ff @(posedge cpu_clk) begin
		if (push)
			stack_mem[PTR_W'(sp)] <= pc_reg + PC_STEP;
	end

	assign pcs.pc_value = pc_reg;
	assign pc           = pc_reg;

	a_no_overflow: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		push |-> (sp != CNT_W'(STACK_DEPTH)));
	a_no_underflow: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		pop |-> (sp != '0));

endmodule

`default_nettype wire

// ==== hdl/chip8_sequencer.sv ====
//############################
// Instruction latch and stage counter
// idle, read, exec, then idle again
//############################
`timescale 1ns/1ps
`default_nettype none

module chip8_sequencer (
	input  logic              cpu_clk,
	input  logic              arst_n,
	input  logic              instr_valid,
	input  chip8_pkg::instr_t instruction,
	output chip8_pkg::stage_e stage,
	output chip8_pkg::instr_t cur_instr,
	output logic              busy
);
	import chip8_pkg::*;

	logic accept;

	// Strobes while busy are dropped
	assign accept = instr_valid && (stage == stage_idle);
	assign busy   = (stage != stage_idle);

	always_ff @(posedge cpu_clk or negedge arst_n) begin
		if (!arst_n) begin
			stage <= stage_idle;
		end else begin
			case (stage)
				stage_idle: if (accept) stage <= stage_read;
				stage_read: stage <= stage_exec;
				default:    stage <= stage_idle;
			endcase
		end
	end

	// Held for both stages
	always_ff @(posedge cpu_clk) begin
		if (accept)
			cur_instr <= instruction;
	end

	a_single_exec: assert property (@(posedge cpu_clk) disable iff (!arst_n)
		(stage == stage_exec) |=> (stage != stage_exec));

endmodule

`default_nettype wire

// ==== hdl/chip8_exec.sv ====
//############################
// Instruction decode and execute control
// Read addresses in stage_read, writes and next PC in stage_exec
// Opcodes not listed fall through as a plain PC step
//############################
`timescale 1ns/1ps
`default_nettype none

module chip8_exec (
	input  chip8_pkg::stage_e stage,
	input  chip8_pkg::instr_t cur_instr,
	regfile_if.exec           rf,
	pc_if.exec                pcs,
	alu_if.exec               alu,
	output logic              commit
);
	import chip8_pkg::*;

	// Instruction fields
	reg_idx_t x_idx;
	reg_idx_t y_idx;
	byte_t    kk;
	addr_t    nnn;

	assign x_idx  = cur_instr[11:8];
	assign y_idx  = cur_instr[7:4];
	assign kk     = cur_instr[7:0];
	assign nnn    = cur_instr[11:0];
	assign commit = (stage == stage_exec);

	always_comb begin
		rf.rd_addr1   = '0;
		rf.rd_addr2   = '0;
		rf.we1        = 1'b0;
		rf.wr_addr1   = x_idx;
		rf.wr_data1   = alu.result;
		rf.we2        = 1'b0;
		rf.wr_addr2   = FLAG_REG;
		rf.wr_data2   = {7'b0, alu.flag};
		rf.i_we       = 1'b0;
		rf.i_wdata    = '0;
		// Step by default, target parked at the current PC
		pcs.pc_src    = pc_next;
		pcs.jump_addr = pcs.pc_value;
		pcs.stk_op    = stk_hold;
		alu.op        = alu_nop;
		alu.a         = rf.rd_data1;
		alu.b         = rf.rd_data2;

		// Same read addresses in both stages
		if (stage != stage_idle) begin
			rf.rd_addr1 = (cur_instr[15:12] == 4'hB) ? 4'h0 : x_idx;
			rf.rd_addr2 = y_idx;
		end

		if (commit) begin
			casez (cur_instr)
				// RET
				16'h00EE: begin
					pcs.pc_src = pc_stack;
					pcs.stk_op = stk_pop;
				end
				16'h1???: begin
					pcs.pc_src    = pc_jump;
					pcs.jump_addr = nnn;
				end
				// CALL pushes the return address
				16'h2???: begin
					pcs.pc_src    = pc_jump;
					pcs.jump_addr = nnn;
					pcs.stk_op    = stk_push;
				end
				16'h3???: if (rf.rd_data1 == kk) pcs.pc_src = pc_skip;
				16'h4???: if (rf.rd_data1 != kk) pcs.pc_src = pc_skip;
				16'h5??0: if (rf.rd_data1 == rf.rd_data2) pcs.pc_src = pc_skip;
				16'h6???: begin
					rf.we1      = 1'b1;
					rf.wr_data1 = kk;
				end
				// Add immediate leaves VF alone
				16'h7???: begin
					alu.op = alu_add;
					alu.b  = kk;
					rf.we1 = 1'b1;
				end
				16'h8???: begin
					case (cur_instr[3:0])
						4'h0: begin
							rf.we1      = 1'b1;
							rf.wr_data1 = rf.rd_data2;
						end
						4'h1: begin
							alu.op = alu_or;
							rf.we1 = 1'b1;
						end
						4'h2: begin
							alu.op = alu_and;
							rf.we1 = 1'b1;
						end
						4'h3: begin
							alu.op = alu_xor;
							rf.we1 = 1'b1;
						end
						4'h4, 4'h5, 4'h6, 4'hE: begin
							case (cur_instr[3:0])
								4'h4:    alu.op = alu_add;
								4'h5:    alu.op = alu_sub;
								4'h6:    alu.op = alu_shr;
								default: alu.op = alu_shl;
							endcase
							rf.we1 = 1'b1;
							rf.we2 = 1'b1;
						end
						// SUBN swaps the operands
						4'h7: begin
							alu.op = alu_sub;
							alu.a  = rf.rd_data2;
							alu.b  = rf.rd_data1;
							rf.we1 = 1'b1;
							rf.we2 = 1'b1;
						end
						default: ;
					endcase
				end
				16'h9??0: if (rf.rd_data1 != rf.rd_data2) pcs.pc_src = pc_skip;
				16'hA???: begin
					rf.i_we    = 1'b1;
					rf.i_wdata = nnn;
				end
				// Target wraps at 12 bits
				16'hB???: begin
					pcs.pc_src    = pc_jump;
					pcs.jump_addr = nnn + addr_t'(rf.rd_data1);
				end
				16'hF?1E: begin
					rf.i_we    = 1'b1;
					rf.i_wdata = rf.i_data + addr_t'(rf.rd_data1);
				end
				// Font glyphs sit at address 0
				16'hF?29: begin
					rf.i_we    = 1'b1;
					rf.i_wdata = addr_t'(rf.rd_data1[3:0]) * FONT_GLYPH_BYTES;
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== hdl/chip8_core.sv ====
//############################
// CHIP-8 execute core, top level
// One instruction per instr_valid strobe while busy is low
// Debug port reads any V register
//############################
`timescale 1ns/1ps
`default_nettype none

module chip8_core #(
	parameter int unsigned STACK_DEPTH = 16
) (
	input  logic                cpu_clk,
	input  logic                arst_n,
	input  logic                instr_valid,
	input  chip8_pkg::instr_t   instruction,
	input  chip8_pkg::reg_idx_t dbg_reg_addr,
	output logic                busy,
	output chip8_pkg::addr_t    pc,
	output chip8_pkg::addr_t    index_reg,
	output chip8_pkg::byte_t    dbg_reg_data
);
	import chip8_pkg::*;

	stage_e stage;
	instr_t cur_instr;
	logic   commit;

	regfile_if rf_bus ();
	pc_if      pc_bus ();
	alu_if     alu_bus ();

	chip8_sequencer u_seq (.cpu_clk, .arst_n, .instr_valid, .instruction,
		.stage, .cur_instr, .busy);
	chip8_exec u_exec (.stage, .cur_instr, .rf(rf_bus.exec), .pcs(pc_bus.exec),
		.alu(alu_bus.exec), .commit);
	chip8_alu u_alu (.alu(alu_bus.alu));
	chip8_regfile u_regs (.cpu_clk, .arst_n, .rf(rf_bus.regfile),
		.dbg_reg_addr, .dbg_reg_data, .index_reg);
	chip8_pc_stack #(.STACK_DEPTH(STACK_DEPTH)) u_pc (.cpu_clk, .arst_n,
		.pcs(pc_bus.pc_unit), .commit, .pc);

endmodule

`default_nettype wire

// ==== sim/tb_chip8_table.svh ====
//############################
// Instruction table for the CHIP-8 core testbench
// One entry per instruction or extra check, expected values by hand
// Included inside the testbench module body
//############################
`ifndef TB_CHIP8_TABLE_SVH
`define TB_CHIP8_TABLE_SVH

// Check kinds
localparam int CHK_V   = 0;
localparam int CHK_I   = 1;
localparam int CHK_PC  = 2;
// PC step with every V register and I unchanged
localparam int CHK_NOP = 3;

// Table columns, one queue each
instr_t   tbl_instr [$];
bit       tbl_issue [$];
int       tbl_kind  [$];
reg_idx_t tbl_idx   [$];
addr_t    tbl_exp   [$];

// Instruction followed by one check
task automatic add_op(input instr_t instr, input int kind, input reg_idx_t idx,
	input addr_t exp);
	tbl_instr.push_back(instr);
	tbl_issue.push_back(1'b1);
	tbl_kind.push_back(kind);
	tbl_idx.push_back(idx);
	tbl_exp.push_back(exp);
endtask

// Check only, no instruction
task automatic add_chk(input int kind, input reg_idx_t idx, input addr_t exp);
	tbl_instr.push_back('0);
	tbl_issue.push_back(1'b0);
	tbl_kind.push_back(kind);
	tbl_idx.push_back(idx);
	tbl_exp.push_back(exp);
endtask

task automatic build_table();
	byte_t ra;
	byte_t rb;
	int    total;
	// Loads, 7xkk keeps VF
	add_op(16'h6A12, CHK_V, 4'hA, 12'h012);
	add_op(16'h7A05, CHK_V, 4'hA, 12'h017);
	add_op(16'h6FFF, CHK_V, 4'hF, 12'h0FF);
	add_op(16'h7AF0, CHK_V, 4'hF, 12'h0FF);
	add_chk(CHK_V, 4'hA, 12'h007);
	// Move and logic ops
	add_op(16'h6B34, CHK_V, 4'hB, 12'h034);
	add_op(16'h8AB0, CHK_V, 4'hA, 12'h034);
	add_op(16'h6C0F, CHK_V, 4'hC, 12'h00F);
	add_op(16'h8AC1, CHK_V, 4'hA, 12'h03F);
	add_op(16'h8AC2, CHK_V, 4'hA, 12'h00F);
	add_op(16'h8AB3, CHK_V, 4'hA, 12'h03B);
	// ADD with and without carry
	add_op(16'h6D80, CHK_V, 4'hD, 12'h080);
	add_op(16'h6EC0, CHK_V, 4'hE, 12'h0C0);
	add_op(16'h8DE4, CHK_V, 4'hD, 12'h040);
	add_chk(CHK_V, 4'hF, 12'h001);
	add_op(16'h6101, CHK_V, 4'h1, 12'h001);
	add_op(16'h6202, CHK_V, 4'h2, 12'h002);
	add_op(16'h8124, CHK_V, 4'h1, 12'h003);
	add_chk(CHK_V, 4'hF, 12'h000);
	// SUB at equal operands sets VF
	add_op(16'h6355, CHK_V, 4'h3, 12'h055);
	add_op(16'h6455, CHK_V, 4'h4, 12'h055);
	add_op(16'h8345, CHK_V, 4'h3, 12'h000);
	add_chk(CHK_V, 4'hF, 12'h001);
	// SUB with borrow
	add_op(16'h6510, CHK_V, 4'h5, 12'h010);
	add_op(16'h6620, CHK_V, 4'h6, 12'h020);
	add_op(16'h8565, CHK_V, 4'h5, 12'h0F0);
	add_chk(CHK_V, 4'hF, 12'h000);
	// SUBN computes Vy minus Vx
	add_op(16'h6710, CHK_V, 4'h7, 12'h010);
	add_op(16'h6830, CHK_V, 4'h8, 12'h030);
	add_op(16'h8787, CHK_V, 4'h7, 12'h020);
	add_chk(CHK_V, 4'hF, 12'h001);
	// Shifts, flag is the bit shifted out
	add_op(16'h6905, CHK_V, 4'h9, 12'h005);
	add_op(16'h8906, CHK_V, 4'h9, 12'h002);
	add_chk(CHK_V, 4'hF, 12'h001);
	add_op(16'h6981, CHK_V, 4'h9, 12'h081);
	add_op(16'h890E, CHK_V, 4'h9, 12'h002);
	add_chk(CHK_V, 4'hF, 12'h001);
	add_op(16'h890E, CHK_V, 4'h9, 12'h004);
	add_chk(CHK_V, 4'hF, 12'h000);
	// ADD into VF, carry wins over the sum
	add_op(16'h6FF0, CHK_V, 4'hF, 12'h0F0);
	add_op(16'h6E20, CHK_V, 4'hE, 12'h020);
	add_op(16'h8FE4, CHK_V, 4'hF, 12'h001);
	// Skips, V1=03 V6=20 V7=20 V8=30
	add_op(16'h3103, CHK_PC, 4'h0, 12'h246);
	add_op(16'h3104, CHK_PC, 4'h0, 12'h248);
	add_op(16'h4104, CHK_PC, 4'h0, 12'h24C);
	add_op(16'h4103, CHK_PC, 4'h0, 12'h24E);
	add_op(16'h5670, CHK_PC, 4'h0, 12'h252);
	add_op(16'h5680, CHK_PC, 4'h0, 12'h254);
	add_op(16'h9680, CHK_PC, 4'h0, 12'h258);
	add_op(16'h9670, CHK_PC, 4'h0, 12'h25A);
	// Jumps, Bnnn wraps at 12 bits
	add_op(16'h1300, CHK_PC, 4'h0, 12'h300);
	add_op(16'h6010, CHK_V, 4'h0, 12'h010);
	add_op(16'hB400, CHK_PC, 4'h0, 12'h410);
	add_op(16'h60F0, CHK_V, 4'h0, 12'h0F0);
	add_op(16'hBFF0, CHK_PC, 4'h0, 12'h0E0);
	add_op(16'h1500, CHK_PC, 4'h0, 12'h500);
	// Three nested calls, then returns
	add_op(16'h2600, CHK_PC, 4'h0, 12'h600);
	add_op(16'h2700, CHK_PC, 4'h0, 12'h700);
	add_op(16'h2800, CHK_PC, 4'h0, 12'h800);
	add_op(16'h00EE, CHK_PC, 4'h0, 12'h702);
	add_op(16'h00EE, CHK_PC, 4'h0, 12'h602);
	add_op(16'h00EE, CHK_PC, 4'h0, 12'h502);
	// Index register
	add_op(16'hA123, CHK_I, 4'h0, 12'h123);
	add_op(16'h6135, CHK_V, 4'h1, 12'h035);
	add_op(16'hF11E, CHK_I, 4'h0, 12'h158);
	add_op(16'hAFF0, CHK_I, 4'h0, 12'hFF0);
	add_op(16'hF61E, CHK_I, 4'h0, 12'h010);
	add_op(16'h6A0B, CHK_V, 4'hA, 12'h00B);
	add_op(16'hFA29, CHK_I, 4'h0, 12'h037);
	// Only the low nibble picks the glyph
	add_op(16'h6A3C, CHK_V, 4'hA, 12'h03C);
	add_op(16'hFA29, CHK_I, 4'h0, 12'h03C);
	// Unknown and dropped opcodes
	add_op(16'h0123, CHK_NOP, 4'h0, 12'h516);
	add_op(16'hE19E, CHK_NOP, 4'h0, 12'h518);
	add_op(16'h8AB8, CHK_NOP, 4'h0, 12'h51A);
	add_op(16'hD123, CHK_NOP, 4'h0, 12'h51C);
	// Random loads and ADD
	for (int k = 0; k < 4; k++) begin
		ra    = byte_t'($urandom);
		rb    = byte_t'($urandom);
		// Carry when the true sum passes 255
		total = int'(ra) + int'(rb);
		add_op({8'h6A, ra}, CHK_V, 4'hA, addr_t'(ra));
		add_op({8'h6B, rb}, CHK_V, 4'hB, addr_t'(rb));
		add_op(16'h8AB4, CHK_V, 4'hA, addr_t'(total % 256));
		add_chk(CHK_V, 4'hF, (total > 255) ? 12'h001 : 12'h000);
	end
	// Twelve more plain steps
	add_chk(CHK_PC, 4'h0, 12'h534);
endtask

`endif

// ==== sim/tb_chip8.sv ====
//############################
// Testbench for the CHIP-8 execute core
// Issues the table entries one by one through the top level ports
// Checks V registers, I, PC and busy length
//############################
`timescale 1ns/1ps
`default_nettype none

module tb_chip8;
	import chip8_pkg::*;

	logic     cpu_clk;
	logic     arst_n;
	logic     instr_valid;
	instr_t   instruction;
	reg_idx_t dbg_reg_addr;
	logic     busy;
	addr_t    pc;
	addr_t    index_reg;
	byte_t    dbg_reg_data;

	int          errors;
	int          checks;
	int          cycle_count;
	int          cycle_limit;
	int unsigned seed;
	// Register values the table has led to so far
	byte_t       model_v [16];
	addr_t       model_i;

	`include "tb_chip8_table.svh"

	chip8_core #(.STACK_DEPTH(16)) i_dut (
		.cpu_clk,
		.arst_n,
		.instr_valid,
		.instruction,
		.dbg_reg_addr,
		.busy,
		.pc,
		.index_reg,
		.dbg_reg_data
	);

	initial cpu_clk = 1'b0;
	always #4 cpu_clk = ~cpu_clk;

	task automatic check_value(input string what, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("[FAIL] %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	// One register per cycle, address driven just after the edge
	task automatic compare_regs();
		for (int r = 0; r < 16; r++) begin
			@(posedge cpu_clk);
			#1;
			dbg_reg_addr = reg_idx_t'(r);
			#1;
			check_value($sformatf("V%0h", r), dbg_reg_data, model_v[r]);
		end
		check_value("I", index_reg, model_i);
	endtask

	task automatic apply_entry(input int n);
		int busy_cycles;
		@(posedge cpu_clk);
		#1;
		if (tbl_issue[n]) begin
			while (busy) begin
				@(posedge cpu_clk);
				#1;
			end
			instr_valid = 1'b1;
			instruction = tbl_instr[n];
			// Accepted on this edge
			@(posedge cpu_clk);
			#1;
			instr_valid = 1'b0;
			busy_cycles = 0;
			while (busy) begin
				busy_cycles++;
				@(posedge cpu_clk);
				#1;
			end
			check_value($sformatf("busy cycles for %h", tbl_instr[n]), busy_cycles, 2);
		end
		dbg_reg_addr = tbl_idx[n];
		#1;
		case (tbl_kind[n])
			CHK_V: begin
				check_value($sformatf("V%0h", tbl_idx[n]), dbg_reg_data, tbl_exp[n]);
				model_v[tbl_idx[n]] = byte_t'(tbl_exp[n]);
			end
			CHK_I: begin
				check_value("I", index_reg, tbl_exp[n]);
				model_i = tbl_exp[n];
			end
			CHK_PC: check_value("pc", pc, tbl_exp[n]);
			default: begin
				check_value("pc", pc, tbl_exp[n]);
				compare_regs();
			end
		endcase
	endtask

	initial begin
		errors       = 0;
		checks       = 0;
		cycle_limit  = 0;
		arst_n       = 1'b0;
		instr_valid  = 1'b0;
		instruction  = '0;
		dbg_reg_addr = '0;
		seed         = 32'h676d_1be6;
		void'($urandom(seed));
		build_table();
		cycle_limit = 10 + 8 * tbl_instr.size();

		repeat (10) @(posedge cpu_clk);
		#1;
		arst_n = 1'b1;

		// State right after reset
		check_value("pc", pc, 12'h200);
		check_value("I", index_reg, 0);
		check_value("busy", busy, 0);
		for (int r = 0; r < 16; r++)
			model_v[r] = '0;
		model_i = '0;
		compare_regs();

		for (int n = 0; n < tbl_instr.size(); n++)
			apply_entry(n);

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

	// Watchdog against a stuck busy level
	initial begin
		cycle_count = 0;
		wait (cycle_limit != 0);
		while (cycle_count < cycle_limit) begin
			@(posedge cpu_clk);
			cycle_count++;
		end
		$display("Timeout: run did not finish within %0d clock cycles", cycle_count);
		$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+sim
hdl/chip8_pkg.sv
hdl/chip8_ifs.sv
hdl/chip8_alu.sv
hdl/chip8_regfile.sv
hdl/chip8_pc_stack.sv
hdl/chip8_sequencer.sv
hdl/chip8_exec.sv
hdl/chip8_core.sv
sim/tb_chip8.sv
